// ==== files.f ====
+incdir+hdl
hdl/spi_flash_pkg.sv
hdl/csr_port.sv
hdl/cache_port.sv
hdl/flash_req_arbiter.sv
hdl/spi_shift_engine.sv
hdl/spi_flash_ctrl.sv
testbench/spi_flash_model.sv
testbench/tb_spi_flash_ctrl.sv

// ==== testbench/tb_spi_flash_ctrl.sv ====
`timescale 1ns/10ps
`include "spi_flash_defs.svh"

module tb_spi_flash_ctrl;
  import spi_flash_pkg::*;

  localparam int DRIVE_DLY   = 2;
  localparam int WORST_BITS  = 8 + `FLASH_ADDR_W + 15 + 32;
  localparam int XFER_CYCLES = WORST_BITS * 2 * `SPI_HALF_SCLK + 20;  // plus handshakes
  localparam int MAX_CYCLES  = 40 * XFER_CYCLES;
  localparam int CACHE_READS = 8;

  logic        clk;
  logic        arst;
  logic        csr_req;
  logic        csr_we;
  csr_idx_t    csr_idx;
  flash_word_t csr_wdata;
  logic        csr_ack;
  flash_word_t csr_rdata;
  logic        cache_req;
  flash_addr_t cache_addr;
  logic        cache_ack;
  flash_word_t cache_rdata;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  logic        miso;
  int          skip_bits;
  flash_word_t cap_bits;
  int          cap_len;
  int          xfer_cnt;

  integer      seed;
  int          cycle_cnt = 0;
  int          cache_ack_cycle = 0;
  int          sw_done_cycle = 0;
  logic        cache_ack_prev = 1'b0;
  logic        cache_ack_rose;
  string       test_name = "init";
  flash_word_t cache_exp_q[$];

  spi_flash_ctrl i_spi_flash_ctrl (
    .clk_i(clk), .arst_i(arst),
    .csr_req_i(csr_req), .csr_we_i(csr_we), .csr_idx_i(csr_idx), .csr_wdata_i(csr_wdata),
    .csr_ack_o(csr_ack), .csr_rdata_o(csr_rdata),
    .cache_req_i(cache_req), .cache_addr_i(cache_addr),
    .cache_ack_o(cache_ack), .cache_rdata_o(cache_rdata),
    .sclk_o(sclk), .ss_n_o(ss_n), .mosi_o(mosi), .miso_i(miso)
  );

  spi_flash_model i_spi_flash_model (
    .sclk_i(sclk), .ss_n_i(ss_n), .mosi_i(mosi), .miso_o(miso),
    .skip_bits_i(skip_bits), .cap_bits_o(cap_bits), .cap_len_o(cap_len),
    .xfer_cnt_o(xfer_cnt)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ==================================================
  // expected values and checks
  // ==================================================

  // a read returns the stored bytes msb first and any other command returns ones
  function automatic flash_word_t model_read(input flash_addr_t addr, input logic [7:0] opcode,
                                             input int nbits);
    flash_word_t word;
    flash_addr_t a;
    word = '0;
    if (opcode == 8'h03) begin
      for (int i = 0; i < 4; i++) begin
        a    = addr + flash_addr_t'(i);
        word = {word[23:0], a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a};
      end
      word = word >> (32 - nbits);
    end else begin
      word = (nbits >= 32) ? 32'hffff_ffff : ((32'h1 << nbits) - 32'h1);
    end
    return word;
  endfunction

  function automatic flash_word_t command_word(input logic [7:0] opcode, input logic addr_en,
                                               input logic [3:0] dummy, input logic [5:0] nbits,
                                               input logic dir);
    flash_cmd_t cmd;
    cmd.opcode       = opcode;
    cmd.addr_en      = addr_en;
    cmd.dummy_cycles = dummy;
    cmd.ndata_bits   = nbits;
    cmd.data_dir     = dir;
    return flash_word_t'(cmd);
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input flash_word_t exp, input flash_word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("FAILED %s (%s): expected %h, actual %h",
                              test_name, what, exp, act));
    end
  endtask

  task automatic check_bits(input string what, input flash_word_t exp, input flash_word_t act,
                            input int nbits);
    flash_word_t mask;
    mask = (nbits >= 32) ? 32'hffff_ffff : ((32'h1 << nbits) - 32'h1);
    if ((act & mask) !== (exp & mask)) begin
      stop_on_error($sformatf("FAILED %s (%s, %0d bits): expected %h, actual %h",
                              test_name, what, nbits, exp & mask, act & mask));
    end
  endtask

  // ==================================================
  // bus handshakes that start and end at drive time
  // ==================================================

  task automatic csr_access(input logic we, input csr_idx_t idx, input flash_word_t wdata,
                            output flash_word_t rdata);
    csr_req   = 1'b1;
    csr_we    = we;
    csr_idx   = idx;
    csr_wdata = wdata;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (csr_ack !== 1'b1);
    rdata   = csr_rdata;
    csr_req = 1'b0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (csr_ack !== 1'b0);
  endtask

  task automatic csr_write(input csr_idx_t idx, input flash_word_t wdata);
    flash_word_t unused;
    csr_access(1'b1, idx, wdata, unused);
  endtask

  task automatic csr_read(input csr_idx_t idx, output flash_word_t rdata);
    csr_access(1'b0, idx, '0, rdata);
  endtask

  task automatic wait_ready();
    flash_word_t rd;
    do begin
      csr_read(`REG_READY, rd);
    end while (rd[0] !== 1'b1);
  endtask

  task automatic wait_frame_start();
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (ss_n !== 1'b0);
  endtask

  task automatic cache_read(input flash_addr_t addr);
    cache_exp_q.push_back(model_read(addr, 8'h03, 32));
    cache_req  = 1'b1;
    cache_addr = addr;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (cache_ack !== 1'b1);
    cache_req = 1'b0;
    do begin
      @(posedge clk);
      #DRIVE_DLY;
    end while (cache_ack !== 1'b0);
  endtask

  function automatic flash_addr_t random_addr();
    flash_word_t r;
    r = $random(seed);
    return r[`FLASH_ADDR_W-1:0];
  endfunction

  // cache data is compared on the cycle its ack rises
  always @(negedge clk) begin
    cache_ack_rose = cache_ack & ~cache_ack_prev;
    cache_ack_prev = cache_ack;
    if (cache_ack_rose === 1'b1) begin
      cache_ack_cycle = cycle_cnt;
      if (cache_exp_q.size() == 0) begin
        stop_on_error("cache ack rose while no cache read was outstanding");
      end else begin
        check_word("cache data", cache_exp_q.pop_front(), cache_rdata);
      end
    end
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    stop_on_error($sformatf("run stopped after %0d cycles with tests still running",
                            MAX_CYCLES));
  end

  // ==================================================
  // tests
  // ==================================================

  task automatic sw_read_test();
    flash_addr_t addr;
    flash_word_t rd;
    test_name = "sw_read";
    addr      = random_addr();
    csr_write(`REG_ADDRESS, flash_word_t'(addr));
    csr_write(`REG_COMMAND, command_word(8'h03, 1'b1, 4'd0, 6'd16, 1'b0));
    csr_write(`REG_START, '0);
    wait_ready();
    csr_read(`REG_DATAOUT, rd);
    check_word("dataout", model_read(addr, 8'h03, 16), rd);
  endtask

  task automatic sw_write_test();
    flash_word_t datain;
    test_name = "sw_write";
    datain    = $random(seed);
    skip_bits = 5;  // no address phase, only the dummy clocks
    csr_write(`REG_DATAIN, datain);
    csr_write(`REG_COMMAND, command_word(8'h42, 1'b0, 4'd5, 6'd20, 1'b1));
    csr_write(`REG_START, '0);
    wait_ready();
    check_bits("captured data", datain, cap_bits, 20);
    check_word("captured length", 32'd20, flash_word_t'(cap_len));
  endtask

  task automatic same_cycle_test();
    flash_addr_t cache_a;
    flash_addr_t sw_a;
    flash_word_t rd;
    test_name = "same_cycle";
    cache_a   = random_addr();
    sw_a      = random_addr();
    csr_write(`REG_ADDRESS, flash_word_t'(sw_a));
    csr_write(`REG_COMMAND, command_word(8'h03, 1'b1, 4'd0, 6'd24, 1'b0));
    fork
      cache_read(cache_a);
      begin
        csr_write(`REG_START, '0);
        wait_ready();
        sw_done_cycle = cycle_cnt;
        csr_read(`REG_DATAOUT, rd);
        check_word("dataout", model_read(sw_a, 8'h03, 24), rd);
      end
    join
    if (cache_ack_cycle >= sw_done_cycle) begin
      stop_on_error("software read finished before the cache ack in the same cycle test");
    end
  endtask

  task automatic drop_and_reset_test();
    int          xfer_before;
    flash_word_t rd;
    test_name = "busy_start";
    csr_write(`REG_ADDRESS, flash_word_t'(random_addr()));
    csr_write(`REG_COMMAND, command_word(8'h03, 1'b1, 4'd0, 6'd32, 1'b0));
    xfer_before = xfer_cnt;
    fork
      cache_read(random_addr());
      begin
        wait_frame_start();
        csr_read(`REG_READY, rd);
        check_word("ready while busy", 32'd0, rd);
        csr_write(`REG_START, '0);  // the cache holds the engine so this start is dropped
      end
    join
    wait_ready();
    check_word("transfer count", 32'd1, flash_word_t'(xfer_cnt - xfer_before));

    test_name = "soft_reset";
    csr_write(`REG_START, '0);
    wait_frame_start();
    repeat (20) @(posedge clk);  // still inside the opcode phase
    #DRIVE_DLY;
    csr_write(`REG_RESET, 32'd1);
    csr_read(`REG_READY, rd);
    check_word("ready after reset", 32'd1, rd);
    check_word("ss_n after reset", 32'd1, flash_word_t'(ss_n));
    cache_read(random_addr());
  endtask

  initial begin
    clk        = 1'b0;
    arst       = 1'b1;
    csr_req    = 1'b0;
    csr_we     = 1'b0;
    csr_idx    = '0;
    csr_wdata  = '0;
    cache_req  = 1'b0;
    cache_addr = '0;
    skip_bits  = 0;
    seed       = 32'h331b07bd;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    arst = 1'b0;

    test_name = "reset";
    check_word("csr ack", 32'd0, flash_word_t'(csr_ack));
    check_word("cache ack", 32'd0, flash_word_t'(cache_ack));
    check_word("ss_n", 32'd1, flash_word_t'(ss_n));
    check_word("sclk", 32'd0, flash_word_t'(sclk));

    test_name = "cache_reads";
    for (int i = 0; i < CACHE_READS; i++) begin
      cache_read(random_addr());
    end
    sw_read_test();
    sw_write_test();
    same_cycle_test();
    drop_and_reset_test();

    if (cache_exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_on_error("cache reads were left without an ack at the end of the run");
    end
  end

endmodule

// ==== testbench/spi_flash_model.sv ====
`timescale 1ns/10ps
`include "spi_flash_defs.svh"

module spi_flash_model (
  input  logic                       sclk_i,
  input  logic                       ss_n_i,
  input  logic                       mosi_i,
  output logic                       miso_o,
  input  int                         skip_bits_i,
  output spi_flash_pkg::flash_word_t cap_bits_o,
  output int                         cap_len_o,
  output int                         xfer_cnt_o
);
  import spi_flash_pkg::*;

  localparam logic [7:0] READ_OP  = `CACHE_READ_OPCODE;
  localparam int         HDR_BITS = 8 + `FLASH_ADDR_W;  // opcode plus address of a read

  int          bit_cnt;
  int          rd_idx;
  logic [7:0]  opcode;
  logic [7:0]  mem_val;
  flash_addr_t addr;
  flash_addr_t byte_addr;

  // every address bit takes part in the stored byte
  function automatic logic [7:0] mem_byte(input flash_addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5a;
  endfunction

  // ==================================================
  // mosi side, sampled on the rising sclk edge
  // ==================================================

  always @(posedge sclk_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      bit_cnt = 0;  // frame over, the next falling ss_n starts a new one
    end else begin
      if (bit_cnt == 0) begin
        xfer_cnt_o = xfer_cnt_o + 1;
        cap_bits_o = '0;
        cap_len_o  = 0;
        opcode     = '0;
      end
      if (bit_cnt < 8) begin
        opcode = {opcode[6:0], mosi_i};
      end else if (opcode == READ_OP && bit_cnt < HDR_BITS) begin
        addr = {addr[`FLASH_ADDR_W-2:0], mosi_i};
      end else if (opcode != READ_OP && bit_cnt >= 8 + skip_bits_i) begin
        cap_bits_o = {cap_bits_o[30:0], mosi_i};  // data bits land right aligned
        cap_len_o  = cap_len_o + 1;
      end
      bit_cnt = bit_cnt + 1;
    end
  end

  // ==================================================
  // miso side, changed on the falling sclk edge
  // ==================================================

  always @(negedge sclk_i or posedge ss_n_i) begin
    if (ss_n_i) begin
      miso_o = 1'b1;
    end else if (opcode == READ_OP && bit_cnt >= HDR_BITS) begin
      rd_idx    = bit_cnt - HDR_BITS;                        // next bit the host will sample
      byte_addr = addr + flash_addr_t'(rd_idx / 8);          // address steps once per byte
      mem_val   = mem_byte(byte_addr);
      miso_o    = mem_val[7 - (rd_idx % 8)];
    end else begin
      miso_o = 1'b1;
    end
  end

endmodule

// ==== hdl/spi_flash_ctrl.sv ====
`timescale 1ns/10ps

module spi_flash_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  logic                       csr_req_i,
  input  logic                       csr_we_i,
  input  spi_flash_pkg::csr_idx_t    csr_idx_i,
  input  spi_flash_pkg::flash_word_t csr_wdata_i,
  output logic                       csr_ack_o,
  output spi_flash_pkg::flash_word_t csr_rdata_o,
  input  logic                       cache_req_i,
  input  spi_flash_pkg::flash_addr_t cache_addr_i,
  output logic                       cache_ack_o,
  output spi_flash_pkg::flash_word_t cache_rdata_o,
  output logic                       sclk_o,
  output logic                       ss_n_o,
  output logic                       mosi_o,
  input  logic                       miso_i
);
  import spi_flash_pkg::*;

  flash_req_t csr_req;
  flash_req_t cache_req;
  flash_req_t eng_req;
  flash_rsp_t arb_rsp;
  flash_rsp_t eng_rsp;
  logic       csr_valid;
  logic       cache_valid;
  logic       csr_done;
  logic       cache_done;
  logic       busy;
  logic       eng_start;
  logic       eng_done;
  logic       soft_clear;
  logic       eng_clear;

  assign eng_clear = arst_i | soft_clear;  // soft reset hits the arbiter and the engine only

  csr_port i_csr_port (
    .clk_i, .arst_i, .csr_req_i, .csr_we_i, .csr_idx_i, .csr_wdata_i,
    .busy_i(busy), .done_i(csr_done), .rsp_i(arb_rsp),
    .csr_ack_o, .csr_rdata_o,
    .req_valid_o(csr_valid), .req_o(csr_req), .soft_clear_o(soft_clear)
  );

  cache_port i_cache_port (
    .clk_i, .arst_i, .cache_req_i, .cache_addr_i,
    .done_i(cache_done), .rsp_i(arb_rsp),
    .cache_ack_o, .cache_rdata_o,
    .req_valid_o(cache_valid), .req_o(cache_req)
  );

  flash_req_arbiter i_arbiter (
    .clk_i, .arst_i, .clear_i(eng_clear),
    .csr_valid_i(csr_valid), .csr_req_i(csr_req),
    .cache_valid_i(cache_valid), .cache_req_i(cache_req),
    .eng_done_i(eng_done), .eng_rsp_i(eng_rsp),
    .csr_done_o(csr_done), .cache_done_o(cache_done), .rsp_o(arb_rsp),
    .busy_o(busy), .eng_start_o(eng_start), .eng_req_o(eng_req)
  );

  spi_shift_engine i_engine (
    .clk_i, .arst_i, .clear_i(eng_clear),
    .start_i(eng_start), .req_i(eng_req), .miso_i,
    .done_o(eng_done), .rsp_o(eng_rsp),
    .sclk_o, .ss_n_o, .mosi_o
  );

endmodule

// ==== hdl/spi_shift_engine.sv ====
`timescale 1ns/10ps
`include "spi_flash_defs.svh"

module spi_shift_engine (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      clear_i,
  input  logic                      start_i,
  input  spi_flash_pkg::flash_req_t req_i,
  input  logic                      miso_i,
  output logic                      done_o,
  output spi_flash_pkg::flash_rsp_t rsp_o,
  output logic                      sclk_o,
  output logic                      ss_n_o,
  output logic                      mosi_o
);
  import spi_flash_pkg::*;

  localparam int HALF_W = ($clog2(`SPI_HALF_SCLK) > 0) ? $clog2(`SPI_HALF_SCLK) : 1;
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`SPI_HALF_SCLK - 1);

  engine_state_t     state_q;
  engine_state_t     nxt_state;
  logic [HALF_W-1:0] half_cnt_q;
  logic [5:0]        bit_cnt_q;
  logic [5:0]        nxt_cnt;
  logic              sclk_q;
  logic              ss_n_q;
  logic              done_q;
  flash_word_t       shift_q;    // bit on mosi is always the msb
  flash_word_t       nxt_shift;
  flash_word_t       rdata_q;
  flash_req_t        req_q;
  logic              shifting;
  logic              half_tick;

  assign shifting  = (state_q == OPCODE) || (state_q == ADDR) ||
                     (state_q == DUMMY) || (state_q == DATA);
  assign half_tick = shifting && (half_cnt_q == HALF_LAST);

  // ==================================================
  // phase sequencing, skipping empty phases
  // ==================================================

  always_comb begin
    nxt_state = FINISH;
    nxt_shift = '0;
    nxt_cnt   = '0;
    if (state_q == OPCODE && req_q.cmd.addr_en) begin
      nxt_state = ADDR;
      nxt_shift = flash_word_t'(req_q.addr) << (32 - `FLASH_ADDR_W);
      nxt_cnt   = 6'(`FLASH_ADDR_W);
    end else if ((state_q == OPCODE || state_q == ADDR) && req_q.cmd.dummy_cycles != 4'd0) begin
      nxt_state = DUMMY;
      nxt_cnt   = {2'b00, req_q.cmd.dummy_cycles};
    end else if (state_q != DATA && req_q.cmd.ndata_bits != 6'd0) begin
      nxt_state = DATA;
      nxt_cnt   = req_q.cmd.ndata_bits;
      if (req_q.cmd.data_dir) begin
        nxt_shift = req_q.wdata << (6'd32 - req_q.cmd.ndata_bits);  // msb of the field first
      end
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q    <= IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sclk_q     <= 1'b0;
      ss_n_q     <= 1'b1;
      done_q     <= 1'b0;
      shift_q    <= '0;
    end else if (clear_i) begin
      state_q    <= IDLE;
      half_cnt_q <= '0;
      bit_cnt_q  <= '0;
      sclk_q     <= 1'b0;
      ss_n_q     <= 1'b1;
      done_q     <= 1'b0;
      shift_q    <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            ss_n_q     <= 1'b0;
            shift_q    <= {req_i.cmd.opcode, 24'h000000};
            bit_cnt_q  <= 6'd8;
            half_cnt_q <= '0;
            state_q    <= OPCODE;
          end
        end
        FINISH: begin
          ss_n_q  <= 1'b1;
          done_q  <= 1'b1;
          state_q <= IDLE;
        end
        default: begin
          if (half_tick) begin
            half_cnt_q <= '0;
            sclk_q     <= ~sclk_q;
            if (sclk_q) begin  // falling edge closes the bit
              if (bit_cnt_q == 6'd1) begin
                state_q   <= nxt_state;
                shift_q   <= nxt_shift;
                bit_cnt_q <= nxt_cnt;
              end else begin
                shift_q   <= {shift_q[30:0], 1'b0};
                bit_cnt_q <= bit_cnt_q - 6'd1;
              end
            end
          end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // miso is taken at the end of the low half, right as sclk rises
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && start_i) begin
      req_q   <= req_i;
      rdata_q <= '0;
    end else if (state_q == DATA && half_tick && !sclk_q && !req_q.cmd.data_dir) begin
      rdata_q <= {rdata_q[30:0], miso_i};
    end
  end

  assign done_o = done_q;
  assign rsp_o  = '{rdata: rdata_q};
  assign sclk_o = sclk_q;
  assign ss_n_o = ss_n_q;
  assign mosi_o = shift_q[31];

endmodule

// ==== hdl/flash_req_arbiter.sv ====
`timescale 1ns/10ps

module flash_req_arbiter (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      clear_i,
  input  logic                      csr_valid_i,
  input  spi_flash_pkg::flash_req_t csr_req_i,
  input  logic                      cache_valid_i,
  input  spi_flash_pkg::flash_req_t cache_req_i,
  input  logic                      eng_done_i,
  input  spi_flash_pkg::flash_rsp_t eng_rsp_i,
  output logic                      csr_done_o,
  output logic                      cache_done_o,
  output spi_flash_pkg::flash_rsp_t rsp_o,
  output logic                      busy_o,
  output logic                      eng_start_o,
  output spi_flash_pkg::flash_req_t eng_req_o
);
  import spi_flash_pkg::*;

  logic       busy_q;
  logic       owner_cache_q;  // set while the cache owns the engine
  logic       start_q;
  flash_req_t eng_req_q;

  // ==================================================
  // grant, cache first
  // ==================================================

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      busy_q        <= 1'b0;
      owner_cache_q <= 1'b0;
      start_q       <= 1'b0;
    end else if (clear_i) begin
      busy_q        <= 1'b0;
      owner_cache_q <= 1'b0;
      start_q       <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (!busy_q) begin
        if (cache_valid_i) begin
          busy_q        <= 1'b1;
          owner_cache_q <= 1'b1;
          start_q       <= 1'b1;
        end else if (csr_valid_i) begin
          busy_q        <= 1'b1;
          owner_cache_q <= 1'b0;
          start_q       <= 1'b1;
        end
      end else if (eng_done_i) begin
        busy_q <= 1'b0;  // the loser still holds valid and is picked next
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_q) eng_req_q <= cache_valid_i ? cache_req_i : csr_req_i;
  end

  assign csr_done_o   = eng_done_i & busy_q & ~owner_cache_q;
  assign cache_done_o = eng_done_i & busy_q & owner_cache_q;
  assign rsp_o        = eng_rsp_i;
  assign busy_o       = busy_q;
  assign eng_start_o  = start_q;
  assign eng_req_o    = eng_req_q;

endmodule

// ==== hdl/cache_port.sv ====
`timescale 1ns/10ps
`include "spi_flash_defs.svh"

module cache_port (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  logic                       cache_req_i,
  input  spi_flash_pkg::flash_addr_t cache_addr_i,
  input  logic                       done_i,
  input  spi_flash_pkg::flash_rsp_t  rsp_i,
  output logic                       cache_ack_o,
  output spi_flash_pkg::flash_word_t cache_rdata_o,
  output logic                       req_valid_o,
  output spi_flash_pkg::flash_req_t  req_o
);
  import spi_flash_pkg::*;

  typedef enum logic [1:0] {
    CP_WAIT,
    CP_PEND,
    CP_ACK
  } cache_state_t;

  // fixed 32 bit read with a 3 byte address
  localparam flash_cmd_t READ_CMD = '{opcode: `CACHE_READ_OPCODE, addr_en: 1'b1,
                                      dummy_cycles: 4'd0, ndata_bits: 6'd32,
                                      data_dir: 1'b0};

  cache_state_t state_q;
  flash_addr_t  addr_q;
  flash_word_t  rdata_q;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state_q <= CP_WAIT;
    end else begin
      case (state_q)
        CP_WAIT: if (cache_req_i) state_q <= CP_PEND;
        CP_PEND: if (done_i) state_q <= CP_ACK;
        CP_ACK:  if (!cache_req_i) state_q <= CP_WAIT;
        default: state_q <= CP_WAIT;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CP_WAIT && cache_req_i) addr_q <= cache_addr_i;
    if (state_q == CP_PEND && done_i) rdata_q <= rsp_i.rdata;
  end

  assign req_valid_o   = (state_q == CP_PEND);
  assign cache_ack_o   = (state_q == CP_ACK);
  assign cache_rdata_o = rdata_q;
  assign req_o         = '{cmd: READ_CMD, addr: addr_q, wdata: '0};

endmodule

// ==== hdl/csr_port.sv ====
`timescale 1ns/10ps
`include "spi_flash_defs.svh"

module csr_port (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  logic                       csr_req_i,
  input  logic                       csr_we_i,
  input  spi_flash_pkg::csr_idx_t    csr_idx_i,
  input  spi_flash_pkg::flash_word_t csr_wdata_i,
  input  logic                       busy_i,
  input  logic                       done_i,
  input  spi_flash_pkg::flash_rsp_t  rsp_i,
  output logic                       csr_ack_o,
  output spi_flash_pkg::flash_word_t csr_rdata_o,
  output logic                       req_valid_o,
  output spi_flash_pkg::flash_req_t  req_o,
  output logic                       soft_clear_o
);
  import spi_flash_pkg::*;

  localparam int CMD_W = $bits(flash_cmd_t);

  flash_addr_t address_q;
  flash_word_t datain_q;
  flash_cmd_t  command_q;
  flash_word_t dataout_q;
  flash_word_t rdata_q;
  flash_word_t rd_word;
  logic        ack_q;
  logic        pend_q;
  logic        req_valid_q;
  logic        soft_clear_q;
  logic        ready;
  logic        start_wr;
  logic        access;
  logic        reset_wr;

  assign ready    = ~(req_valid_q | busy_i);
  assign start_wr = csr_req_i & ~ack_q & csr_we_i & (csr_idx_i == `REG_START);
  assign access   = csr_req_i & ~ack_q & pend_q;  // second cycle of a plain access
  assign reset_wr = access & csr_we_i & (csr_idx_i == `REG_RESET);

  // ==================================================
  // four phase handshake
  // ==================================================

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      ack_q  <= 1'b0;
      pend_q <= 1'b0;
    end else if (ack_q) begin
      if (!csr_req_i) ack_q <= 1'b0;  // hold ack until the master lets go
    end else if (start_wr || access) begin
      ack_q  <= 1'b1;
      pend_q <= 1'b0;
    end else if (csr_req_i) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      req_valid_q  <= 1'b0;
      soft_clear_q <= 1'b0;
    end else begin
      soft_clear_q <= reset_wr;
      if (reset_wr) req_valid_q <= 1'b0;
      else if (start_wr && ready) req_valid_q <= 1'b1;  // a busy start is dropped
      else if (done_i) req_valid_q <= 1'b0;
    end
  end

  always_comb begin
    rd_word = '0;
    case (csr_idx_i)
      `REG_ADDRESS: rd_word = flash_word_t'(address_q);
      `REG_DATAIN:  rd_word = datain_q;
      `REG_COMMAND: rd_word = flash_word_t'(command_q);
      `REG_READY:   rd_word = flash_word_t'(ready);
      `REG_DATAOUT: rd_word = dataout_q;
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access && csr_we_i) begin
      case (csr_idx_i)
        `REG_ADDRESS: address_q <= csr_wdata_i[`FLASH_ADDR_W-1:0];
        `REG_DATAIN:  datain_q  <= csr_wdata_i;
        `REG_COMMAND: command_q <= flash_cmd_t'(csr_wdata_i[CMD_W-1:0]);
        default: ;
      endcase
    end
    if (access && !csr_we_i) rdata_q <= rd_word;
    if (done_i && !command_q.data_dir) dataout_q <= rsp_i.rdata;  // only reads update it
  end

  assign csr_ack_o    = ack_q;
  assign csr_rdata_o  = rdata_q;
  assign req_valid_o  = req_valid_q;
  assign req_o        = '{cmd: command_q, addr: address_q, wdata: datain_q};
  assign soft_clear_o = soft_clear_q;

endmodule

// ==== hdl/spi_flash_pkg.sv ====
`include "spi_flash_defs.svh"

package spi_flash_pkg;

  typedef logic [`FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [31:0]              flash_word_t;
  typedef logic [2:0]               csr_idx_t;

  // ==================================================
  // command and request records
  // ==================================================

  typedef struct packed {
    logic [7:0] opcode;
    logic       addr_en;
    logic [3:0] dummy_cycles;
    logic [5:0] ndata_bits;      // 0 to 32
    logic       data_dir;        // set for a write to the flash
  } flash_cmd_t;

  typedef struct packed {
    flash_cmd_t  cmd;
    flash_addr_t addr;
    flash_word_t wdata;
  } flash_req_t;

  typedef struct packed {
    flash_word_t rdata;          // read bits right aligned
  } flash_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    OPCODE,
    ADDR,
    DUMMY,
    DATA,
    FINISH
  } engine_state_t;

endpackage

// ==== hdl/spi_flash_defs.svh ====
`ifndef SPI_FLASH_DEFS_SVH
`define SPI_FLASH_DEFS_SVH

// ==================================================
// serial flash controller constants
// ==================================================

`define SPI_HALF_SCLK     2        // system clocks per sclk half period
`define FLASH_ADDR_W      24
`define CACHE_READ_OPCODE 8'h03    // plain single lane read

// register word indices
`define REG_ADDRESS       3'd0
`define REG_DATAIN        3'd1
`define REG_COMMAND       3'd2
`define REG_START         3'd3
`define REG_RESET         3'd4
`define REG_READY         3'd5
`define REG_DATAOUT       3'd6

`endif
